// File: mpeg_sys_demux.f
hdl/mpeg_sys_pkg.sv
hdl/field_load_if.sv
hdl/serial_byte_framer.sv
hdl/stream_parser.sv
hdl/pes_header_parser.sv
hdl/field_capture.sv
hdl/mpeg_sys_demux.sv
test/tb_clock_gen.sv
test/mpeg_sys_demux_props.sv
test/tb_mpeg_sys_demux.sv

// File: run_sim.sh
#!/bin/sh
# build the demux testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_mpeg_sys_demux -f mpeg_sys_demux.f -o sim_tb > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "=== FAIL ===" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without passing"; exit 1; }
exit 0

// File: test/tb_mpeg_sys_demux.sv
// MPEG-1 system demux testbench that serializes a table-built stream and checks each output
`timescale 1ns/1ps

module tb_mpeg_sys_demux;
   import mpeg_sys_pkg::*;

   localparam logic [1:0] ROW_PACK = 2'd0;
   localparam logic [1:0] ROW_SYS  = 2'd1;
   localparam logic [1:0] ROW_PKT  = 2'd2;
   localparam logic [1:0] ROW_END  = 2'd3;
   localparam logic [1:0] TS_NONE  = 2'd0;
   localparam logic [1:0] TS_PTS   = 2'd1;
   localparam logic [1:0] TS_BOTH  = 2'd2;
   localparam logic [1:0] EV_PACK  = 2'd0;
   localparam logic [1:0] EV_PTS   = 2'd1;
   localparam logic [1:0] EV_PAY   = 2'd2;
   localparam int         NUM_ROWS = 9;

   typedef struct packed {
      logic [1:0] kind;
      scr_t       scr;
      mux_rate_t  mux;
      byte_t      sid;
      logic [3:0] stuff;   // count of FF bytes
      logic       std_on;
      logic [1:0] ts_mode;
      pts_t       pts;
      logic [7:0] pay_len; // payload bytes, or system header length
   } row_t;

   typedef struct packed {
      logic [1:0] kind;
      pts_t       ts;      // scr or pts
      mux_rate_t  mux;
      byte_t      data;
      byte_t      sid;
   } event_t;

   logic      clk;
   logic      arst_n;
   logic      serial_in;
   scr_t      scr;
   mux_rate_t mux_rate;
   logic      pack_strobe;
   pts_t      pts;
   logic      pts_strobe;
   byte_t     stream_id;
   byte_t     payload_byte;
   logic      payload_strobe;
   logic      stream_end;

   row_t   rows [NUM_ROWS];
   byte_t  stream_q [$];
   event_t exp_q [$];
   int     end_idx     = -1;  // index of the end code byte
   int     cycle_cnt   = 0;
   int     cycle_limit = 0;
   logic   end_sent    = 1'b0;
   logic   end_seen    = 1'b0;
   logic   fail_shown  = 1'b0;
   logic   run_done    = 1'b0;

   tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(3)) u_clock_gen (.clk(clk), .arst_n(arst_n));

   mpeg_sys_demux DUT (
      .clk            (clk),
      .arst_n         (arst_n),
      .serial_in      (serial_in),
      .scr            (scr),
      .mux_rate       (mux_rate),
      .pack_strobe    (pack_strobe),
      .pts            (pts),
      .pts_strobe     (pts_strobe),
      .stream_id      (stream_id),
      .payload_byte   (payload_byte),
      .payload_strobe (payload_strobe),
      .stream_end     (stream_end)
   );

   bind mpeg_sys_demux mpeg_sys_demux_props u_props (
      .clk            (clk),
      .arst_n         (arst_n),
      .pack_strobe    (pack_strobe),
      .pts_strobe     (pts_strobe),
      .payload_strobe (payload_strobe),
      .stream_end     (stream_end)
   );

   task automatic stop_run();
      fail_shown = 1'b1;
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_scr(input string name, input scr_t got, input scr_t exp);
      if (got !== exp)
      begin
         $display("** Error at time %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_mux(input string name, input mux_rate_t got, input mux_rate_t exp);
      if (got !== exp)
      begin
         $display("** Error at time %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_pts(input string name, input pts_t got, input pts_t exp);
      if (got !== exp)
      begin
         $display("** Error at time %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_byte(input string name, input byte_t got, input byte_t exp);
      if (got !== exp)
      begin
         $display("** Error at time %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("** Error at time %0t: %s = %b, expected %b", $time, name, got, exp);
         stop_run();
      end
   endtask

   function automatic row_t make_row(input logic [1:0] kind, input scr_t scr_v,
                                     input mux_rate_t mux_v, input byte_t sid,
                                     input logic [3:0] stuff, input logic std_on,
                                     input logic [1:0] ts_mode, input pts_t pts_v,
                                     input logic [7:0] pay_len);
      row_t r;
      r.kind    = kind;
      r.scr     = scr_v;
      r.mux     = mux_v;
      r.sid     = sid;
      r.stuff   = stuff;
      r.std_on  = std_on;
      r.ts_mode = ts_mode;
      r.pts     = pts_v;
      r.pay_len = pay_len;
      return r;
   endfunction

   function automatic void push_event(input logic [1:0] kind, input pts_t ts,
                                      input mux_rate_t mux, input byte_t data, input byte_t sid);
      event_t ev;
      ev.kind = kind;
      ev.ts   = ts;
      ev.mux  = mux;
      ev.data = data;
      ev.sid  = sid;
      exp_q.push_back(ev);
   endfunction

   function automatic void push_code(input byte_t code);
      stream_q.push_back(8'h00);
      stream_q.push_back(8'h00);
      stream_q.push_back(8'h01);
      stream_q.push_back(code);
   endfunction

   // 33-bit time stamp in 5 bytes with marker bits set
   function automatic void push_ts(input logic [3:0] prefix, input logic [32:0] ts);
      stream_q.push_back({prefix, ts[32:30], 1'b1});
      stream_q.push_back(ts[29:22]);
      stream_q.push_back({ts[21:15], 1'b1});
      stream_q.push_back(ts[14:7]);
      stream_q.push_back({ts[6:0], 1'b1});
   endfunction

   function automatic void add_pack(input row_t r);
      push_code(8'hBA);
      push_ts(4'b0010, r.scr);
      stream_q.push_back({1'b1, r.mux[21:15]});
      stream_q.push_back(r.mux[14:7]);
      stream_q.push_back({r.mux[6:0], 1'b1});
      push_event(EV_PACK, r.scr, r.mux, 8'h00, 8'h00);
   endfunction

   function automatic void add_sys(input row_t r);
      logic [31:0] rnd;
      push_code(8'hBB);
      stream_q.push_back(8'h00);
      stream_q.push_back(r.pay_len);
      for (int i = 0; i < int'(r.pay_len); i++)
      begin
         rnd = $urandom;
         stream_q.push_back(rnd[7:0]);
      end
   endfunction

   function automatic void add_packet(input row_t r);
      logic [31:0] rnd;
      logic [15:0] len;
      byte_t       b;
      int          hdr;
      hdr = int'(r.stuff) + (r.std_on ? 2 : 0);
      hdr = hdr + ((r.ts_mode == TS_NONE) ? 1 : (r.ts_mode == TS_PTS) ? 5 : 10);
      if (r.sid == 8'hBF)
         hdr = 0; // private stream 2 has no packet header
      len = 16'(hdr + int'(r.pay_len));
      push_code(r.sid);
      stream_q.push_back(len[15:8]);
      stream_q.push_back(len[7:0]);
      if (r.sid != 8'hBF)
      begin
         for (int i = 0; i < int'(r.stuff); i++)
            stream_q.push_back(8'hFF);
         if (r.std_on)
         begin
            stream_q.push_back(8'h63); // 01, scale 1, size high bits
            stream_q.push_back(8'h40);
         end
         if (r.ts_mode == TS_NONE)
            stream_q.push_back(8'h0F);
         else
         begin
            push_ts((r.ts_mode == TS_PTS) ? 4'b0010 : 4'b0011, r.pts);
            push_event(EV_PTS, r.pts, 22'h0, 8'h00, r.sid);
            if (r.ts_mode == TS_BOTH)
               push_ts(4'b0001, r.pts - 33'd3003); // dts never reaches the outputs
         end
      end
      for (int i = 0; i < int'(r.pay_len); i++)
      begin
         rnd = $urandom;
         b   = rnd[7:0];
         if (r.sid == 8'hBF)
         begin
            // stuffing value and a full pack start code inside the payload
            if (i == 0 || i == 7)
               b = 8'hFF;
            else if (i == 3 || i == 4)
               b = 8'h00;
            else if (i == 5)
               b = 8'h01;
            else if (i == 6)
               b = 8'hBA;
         end
         stream_q.push_back(b);
         push_event(EV_PAY, 33'h0, 22'h0, b, r.sid);
      end
   endfunction

   task automatic load_table();
      rows[0] = make_row(ROW_PACK, 33'h1_2345_6789, 22'h2_A5C3, 8'h00, 4'd0, 1'b0, TS_NONE,
                         33'h0, 8'd0);
      rows[1] = make_row(ROW_SYS, 33'h0, 22'h0, 8'h00, 4'd0, 1'b0, TS_NONE, 33'h0, 8'd12);
      rows[2] = make_row(ROW_PKT, 33'h0, 22'h0, 8'hE0, 4'd3, 1'b1, TS_PTS,
                         33'h1_FEDC_BA98, 8'd12);
      rows[3] = make_row(ROW_PKT, 33'h0, 22'h0, 8'hC0, 4'd0, 1'b0, TS_BOTH,
                         33'h0_0001_2345, 8'd8);
      rows[4] = make_row(ROW_PKT, 33'h0, 22'h0, 8'hE1, 4'd1, 1'b1, TS_NONE, 33'h0, 8'd6);
      rows[5] = make_row(ROW_PACK, 33'h0_FFFF_FFFF, 22'h3F_FFFF, 8'h00, 4'd0, 1'b0, TS_NONE,
                         33'h0, 8'd0);
      rows[6] = make_row(ROW_PKT, 33'h0, 22'h0, 8'hBF, 4'd0, 1'b0, TS_NONE, 33'h0, 8'd10);
      rows[7] = make_row(ROW_PKT, 33'h0, 22'h0, 8'hBD, 4'd2, 1'b0, TS_PTS,
                         33'h1_0000_0001, 8'd5);
      rows[8] = make_row(ROW_END, 33'h0, 22'h0, 8'h00, 4'd0, 1'b0, TS_NONE, 33'h0, 8'd0);
   endtask

   task automatic build_stream();
      byte_t junk [7];
      junk = '{8'h47, 8'h00, 8'h00, 8'h02, 8'hBA, 8'h01, 8'hFF}; // near miss on a prefix
      foreach (junk[i])
         stream_q.push_back(junk[i]);
      for (int n = 0; n < NUM_ROWS; n++)
      begin
         case (rows[n].kind)
            ROW_PACK: add_pack(rows[n]);
            ROW_SYS:  add_sys(rows[n]);
            ROW_PKT:  add_packet(rows[n]);
            default:
            begin
               push_code(8'hB9);
               end_idx = stream_q.size() - 1;
            end
         endcase
      end
      stream_q.push_back(8'hFF);
      stream_q.push_back(8'hFF);
   endtask

   task automatic send_stream();
      wait (arst_n === 1'b1);
      foreach (stream_q[i])
      begin
         for (int b = 7; b >= 0; b--)
         begin
            if (i == end_idx)
               end_sent = 1'b1;
            serial_in = stream_q[i][b]; // msb first
            @(posedge clk);
            #1;
         end
      end
      serial_in = 1'b0;
   endtask

   task automatic take_event(input logic [1:0] kind, input string name);
      event_t ev;
      if (exp_q.size() == 0)
      begin
         $display("%s at time %0t while no output was expected", name, $time);
         stop_run();
      end
      else
      begin
         ev = exp_q.pop_front();
         if (ev.kind != kind)
         begin
            $display("%s at time %0t while a different output was expected next", name, $time);
            stop_run();
         end
         else if (kind == EV_PACK)
         begin
            check_scr("scr", scr, ev.ts);
            check_mux("mux_rate", mux_rate, ev.mux);
         end
         else if (kind == EV_PTS)
         begin
            check_pts("pts", pts, ev.ts);
            check_byte("stream_id", stream_id, ev.sid);
         end
         else
         begin
            check_byte("payload_byte", payload_byte, ev.data);
            check_byte("stream_id", stream_id, ev.sid);
         end
      end
   endtask

   // outputs change on the rising edge, so look at them on the falling one
   always @(negedge clk)
   begin
      if (arst_n)
      begin
         if (stream_end && !end_sent)
         begin
            $display("stream_end rose at time %0t before the end code was sent", $time);
            stop_run();
         end
         if (end_seen)
            check_flag("stream_end", stream_end, 1'b1); // sticky
         if (stream_end)
            end_seen = 1'b1;
         if (pack_strobe)
            take_event(EV_PACK, "pack_strobe");
         if (pts_strobe)
            take_event(EV_PTS, "pts_strobe");
         if (payload_strobe)
            take_event(EV_PAY, "payload_strobe");
      end
   end

   always @(posedge clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt > cycle_limit)
      begin
         $display("timeout after %0d cycles, %0d expected outputs never appeared",
                  cycle_cnt, exp_q.size());
         stop_run();
      end
   end

   initial
   begin
      serial_in = 1'b0;
      void'($urandom(32'h7028106a));
      load_table();
      build_stream();
      cycle_limit = stream_q.size() * 8 + 200;
      send_stream();
      repeat (8) @(posedge clk); // last output is due 3 edges after its last bit
      check_flag("stream_end", stream_end, 1'b1);
      if (exp_q.size() == 0)
      begin
         run_done = 1'b1;
         $display("=== PASS ===");
         $finish;
      end
      else
      begin
         $display("%0d expected outputs were never seen", exp_q.size());
         stop_run();
      end
   end

   final
   begin
      if (!run_done && !fail_shown)
         $display("=== FAIL ===");
   end

endmodule

// File: test/mpeg_sys_demux_props.sv
// Strobe protocol checks for the demux outputs, bound onto the top level
`timescale 1ns/1ps

module mpeg_sys_demux_props (
   input logic clk,
   input logic arst_n,
   input logic pack_strobe,
   input logic pts_strobe,
   input logic payload_strobe,
   input logic stream_end
);
   logic       any_strobe;
   logic [6:0] pay_hist; // payload strobes seen on the last 7 edges

   assign any_strobe = pack_strobe || pts_strobe || payload_strobe;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         pay_hist <= '0;
      else
         pay_hist <= {pay_hist[5:0], payload_strobe};
   end

   reset_quiet: assert property (@(posedge clk) !arst_n |-> !any_strobe && !stream_end)
      else $error("output strobe or stream_end high while reset is held");

   pack_single: assert property (@(posedge clk) disable iff (!arst_n)
      pack_strobe |=> !pack_strobe)
      else $error("pack_strobe longer than one cycle");

   pts_single: assert property (@(posedge clk) disable iff (!arst_n)
      pts_strobe |=> !pts_strobe)
      else $error("pts_strobe longer than one cycle");

   payload_single: assert property (@(posedge clk) disable iff (!arst_n)
      payload_strobe |=> !payload_strobe)
      else $error("payload_strobe longer than one cycle");

   pack_payload_apart: assert property (@(posedge clk) disable iff (!arst_n)
      !(pack_strobe && payload_strobe))
      else $error("pack_strobe and payload_strobe high together");

   payload_gap: assert property (@(posedge clk) disable iff (!arst_n)
      any_strobe |-> (pay_hist == '0))
      else $error("strobe within 7 cycles of a payload_strobe");

endmodule

// File: test/tb_clock_gen.sv
// Testbench clock and reset source, free-running clock with an active-low reset
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 3
) (
   output logic clk,
   output logic arst_n
);

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   initial
   begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 arst_n = 1'b1; // released just after an edge
   end

endmodule

// File: hdl/mpeg_sys_demux.sv
// MPEG-1 system stream demux top, from serial bits to pack fields, time stamps and payload
`timescale 1ns/1ps

module mpeg_sys_demux (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    serial_in,
   output mpeg_sys_pkg::scr_t      scr,
   output mpeg_sys_pkg::mux_rate_t mux_rate,
   output logic                    pack_strobe,
   output mpeg_sys_pkg::pts_t      pts,
   output logic                    pts_strobe,
   output mpeg_sys_pkg::byte_t     stream_id,
   output mpeg_sys_pkg::byte_t     payload_byte,
   output logic                    payload_strobe,
   output logic                    stream_end
);
   import mpeg_sys_pkg::*;

   byte_t    byte_data;
   logic     byte_strobe;
   logic     after_prefix;
   logic     pes_start;
   logic     pes_busy;
   byte_t    pkt_stream_id; // id latched at the code byte
   pkt_len_t packet_length;

   field_load_if pack_fields ();
   field_load_if pes_fields ();

   serial_byte_framer u_framer (
      .clk          (clk),
      .arst_n       (arst_n),
      .serial_in    (serial_in),
      .byte_data    (byte_data),
      .byte_strobe  (byte_strobe),
      .after_prefix (after_prefix)
   );

   stream_parser u_stream_parser (
      .clk           (clk),
      .arst_n        (arst_n),
      .byte_data     (byte_data),
      .byte_strobe   (byte_strobe),
      .after_prefix  (after_prefix),
      .pack_fields   (pack_fields.src),
      .pes_start     (pes_start),
      .stream_id     (pkt_stream_id),
      .packet_length (packet_length),
      .pes_busy      (pes_busy),
      .stream_end    (stream_end)
   );

   pes_header_parser u_pes_parser (
      .clk           (clk),
      .arst_n        (arst_n),
      .byte_data     (byte_data),
      .byte_strobe   (byte_strobe),
      .pes_start     (pes_start),
      .stream_id     (pkt_stream_id),
      .packet_length (packet_length),
      .pes_fields    (pes_fields.src),
      .pes_busy      (pes_busy)
   );

   field_capture u_capture (
      .clk            (clk),
      .arst_n         (arst_n),
      .pack_fields    (pack_fields.dst),
      .pes_fields     (pes_fields.dst),
      .scr            (scr),
      .mux_rate       (mux_rate),
      .pack_strobe    (pack_strobe),
      .pts            (pts),
      .pts_strobe     (pts_strobe),
      .stream_id      (stream_id),
      .payload_byte   (payload_byte),
      .payload_strobe (payload_strobe)
   );

endmodule

// File: hdl/field_capture.sv
// Field capture block that builds output fields from parsed header bytes and drives the strobes
`timescale 1ns/1ps

module field_capture (
   input  logic                    clk,
   input  logic                    arst_n,
   field_load_if.dst               pack_fields,
   field_load_if.dst               pes_fields,
   output mpeg_sys_pkg::scr_t      scr,
   output mpeg_sys_pkg::mux_rate_t mux_rate,
   output logic                    pack_strobe,
   output mpeg_sys_pkg::pts_t      pts,
   output logic                    pts_strobe,
   output mpeg_sys_pkg::byte_t     stream_id,
   output mpeg_sys_pkg::byte_t     payload_byte,
   output logic                    payload_strobe
);
   import mpeg_sys_pkg::*;

   scr_t       scr_sh;
   scr_t       scr_nxt;
   pts_t       pts_sh;
   pts_t       pts_nxt;
   mux_rate_t  mux_sh;
   mux_rate_t  mux_nxt;
   logic [2:0] scr_idx;
   logic [2:0] pts_idx;
   logic [1:0] mux_idx;

   // 5-byte time stamp layout with marker bits dropped
   function automatic logic [32:0] place_ts(logic [32:0] cur, logic [2:0] idx, byte_t b);
      logic [32:0] ts;
      ts = cur;
      case (idx)
         3'd0:    ts[32:30] = b[3:1];
         3'd1:    ts[29:22] = b;
         3'd2:    ts[21:15] = b[7:1];
         3'd3:    ts[14:7]  = b;
         default: ts[6:0]   = b[7:1];
      endcase
      return ts;
   endfunction

   always_comb
   begin
      scr_nxt = place_ts(scr_sh, scr_idx, pack_fields.data);
      pts_nxt = place_ts(pts_sh, pts_idx, pes_fields.data);
      mux_nxt = mux_sh;
      case (mux_idx)
         2'd0:    mux_nxt[21:15] = pack_fields.data[6:0];
         2'd1:    mux_nxt[14:7]  = pack_fields.data;
         default: mux_nxt[6:0]   = pack_fields.data[7:1];
      endcase
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         scr_sh         <= '0;
         pts_sh         <= '0;
         mux_sh         <= '0;
         scr_idx        <= '0;
         pts_idx        <= '0;
         mux_idx        <= '0;
         scr            <= '0;
         mux_rate       <= '0;
         pts            <= '0;
         stream_id      <= '0;
         payload_byte   <= '0;
         pack_strobe    <= 1'b0;
         pts_strobe     <= 1'b0;
         payload_strobe <= 1'b0;
      end
      else
      begin
         pack_strobe    <= 1'b0;
         pts_strobe     <= 1'b0;
         payload_strobe <= 1'b0;
         if (pack_fields.load && (pack_fields.field == FIELD_SCR))
         begin
            scr_sh  <= scr_nxt;
            scr_idx <= pack_fields.last ? 3'd0 : scr_idx + 3'd1;
         end
         if (pack_fields.load && (pack_fields.field == FIELD_MUX_RATE))
         begin
            mux_sh  <= mux_nxt;
            mux_idx <= pack_fields.last ? 2'd0 : mux_idx + 2'd1;
            if (pack_fields.last)
            begin
               scr         <= scr_sh; // scr finished three bytes ago
               mux_rate    <= mux_nxt;
               pack_strobe <= 1'b1;
            end
         end
         if (pes_fields.load)
         begin
            case (pes_fields.field)
               FIELD_STREAM_ID:
                  stream_id <= pes_fields.data;
               FIELD_PTS:
               begin
                  pts_sh  <= pts_nxt;
                  pts_idx <= pes_fields.last ? 3'd0 : pts_idx + 3'd1;
                  if (pes_fields.last)
                  begin
                     pts        <= pts_nxt;
                     pts_strobe <= 1'b1;
                  end
               end
               FIELD_PAYLOAD:
               begin
                  payload_byte   <= pes_fields.data;
                  payload_strobe <= 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

endmodule

// File: hdl/pes_header_parser.sv
// Packet layer parser for stuffing, STD field, time stamps and payload delivery
`timescale 1ns/1ps

module pes_header_parser (
   input  logic                   clk,
   input  logic                   arst_n,
   input  mpeg_sys_pkg::byte_t    byte_data,
   input  logic                   byte_strobe,
   input  logic                   pes_start,
   input  mpeg_sys_pkg::byte_t    stream_id,
   input  mpeg_sys_pkg::pkt_len_t packet_length,
   field_load_if.src              pes_fields,
   output logic                   pes_busy
);
   import mpeg_sys_pkg::*;

   pes_state_e state;
   pkt_len_t   rem;    // bytes left in the packet
   logic [2:0] ts_cnt; // byte index within a time stamp

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state            <= IDLE;
         rem              <= '0;
         ts_cnt           <= '0;
         pes_fields.load  <= 1'b0;
         pes_fields.data  <= '0;
         pes_fields.field <= FIELD_PAYLOAD;
         pes_fields.last  <= 1'b0;
      end
      else
      begin
         pes_fields.load <= 1'b0;
         if (state == IDLE)
         begin
            if (pes_start)
            begin
               rem              <= packet_length;
               ts_cnt           <= '0;
               pes_fields.load  <= 1'b1;
               pes_fields.data  <= stream_id;
               pes_fields.field <= FIELD_STREAM_ID;
               pes_fields.last  <= 1'b1;
               if (packet_length != '0)
                  state <= (stream_id == PRIVATE_2_ID) ? PAYLOAD : STUFF; // no header in stream 2
            end
         end
         else if (byte_strobe)
         begin
            rem <= rem - 16'd1;
            case (state)
               STUFF:
               begin
                  if (byte_data != STUFFING_BYTE)
                  begin
                     if (byte_data[7:6] == 2'b01)
                        state <= STD_2ND; // buffer scale and size, skipped
                     else if (byte_data[7:5] == TS_MARK)
                     begin
                        // marker byte also holds pts bits 32:30
                        pes_fields.load  <= 1'b1;
                        pes_fields.data  <= byte_data;
                        pes_fields.field <= FIELD_PTS;
                        pes_fields.last  <= 1'b0;
                        ts_cnt           <= 3'd1;
                        state            <= byte_data[4] ? PTS_DTS : PTS;
                     end
                     else if (byte_data == NO_TS_BYTE)
                        state <= PAYLOAD;
                  end
               end
               STD_2ND:
                  state <= STUFF; // next byte is the time stamp marker
               PTS, PTS_DTS:
               begin
                  pes_fields.load  <= 1'b1;
                  pes_fields.data  <= byte_data;
                  pes_fields.field <= FIELD_PTS;
                  pes_fields.last  <= (ts_cnt == 3'd4);
                  ts_cnt           <= ts_cnt + 3'd1;
                  if (ts_cnt == 3'd4)
                  begin
                     ts_cnt <= '0;
                     state  <= (state == PTS) ? PAYLOAD : DTS_SKIP;
                  end
               end
               DTS_SKIP:
               begin
                  ts_cnt <= ts_cnt + 3'd1;
                  if (ts_cnt == 3'd4)
                  begin
                     ts_cnt <= '0;
                     state  <= PAYLOAD;
                  end
               end
               PAYLOAD:
               begin
                  pes_fields.load  <= 1'b1;
                  pes_fields.data  <= byte_data;
                  pes_fields.field <= FIELD_PAYLOAD;
                  pes_fields.last  <= 1'b1; // every payload byte stands alone
               end
               default:
                  state <= IDLE;
            endcase
            if (rem == 16'd1)
               state <= IDLE; // last byte of the packet
         end
      end
   end

   assign pes_busy = (state != IDLE);

endmodule

// File: hdl/stream_parser.sv
// Pack layer parser for start code dispatch, pack header, system header skip and end code
`timescale 1ns/1ps

module stream_parser (
   input  logic                   clk,
   input  logic                   arst_n,
   input  mpeg_sys_pkg::byte_t    byte_data,
   input  logic                   byte_strobe,
   input  logic                   after_prefix,
   field_load_if.src              pack_fields,
   output logic                   pes_start,
   output mpeg_sys_pkg::byte_t    stream_id,
   output mpeg_sys_pkg::pkt_len_t packet_length,
   input  logic                   pes_busy,
   output logic                   stream_end
);
   import mpeg_sys_pkg::*;

   pack_state_e state;
   logic [2:0]  cnt; // byte index within header or length field

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state             <= HUNT;
         cnt               <= '0;
         packet_length     <= '0;
         stream_id         <= '0;
         pes_start         <= 1'b0;
         stream_end        <= 1'b0;
         pack_fields.load  <= 1'b0;
         pack_fields.data  <= '0;
         pack_fields.field <= FIELD_SCR;
         pack_fields.last  <= 1'b0;
      end
      else
      begin
         pes_start        <= 1'b0;
         pack_fields.load <= 1'b0;
         case (state)
            HUNT:
            begin
               // only code bytes are looked at here, payload never reaches this state
               if (byte_strobe && after_prefix)
               begin
                  cnt <= '0;
                  if (byte_data == PACK_START_CODE)
                     state <= PACK_HDR;
                  else if (byte_data == SYSTEM_HEADER_CODE)
                     state <= SYS_LEN;
                  else if (byte_data == END_CODE)
                     stream_end <= 1'b1; // sticky until reset
                  else if (byte_data >= MIN_STREAM_ID)
                  begin
                     stream_id <= byte_data;
                     state     <= PES_LEN;
                  end
               end
            end
            PACK_HDR:
            begin
               if (byte_strobe)
               begin
                  pack_fields.load  <= 1'b1;
                  pack_fields.data  <= byte_data;
                  pack_fields.field <= (cnt < 3'd5) ? FIELD_SCR : FIELD_MUX_RATE;
                  pack_fields.last  <= (cnt == 3'd4) || (cnt == 3'd7); // scr 5, mux 3
                  cnt               <= cnt + 3'd1;
                  if (cnt == 3'd7)
                     state <= HUNT;
               end
            end
            SYS_LEN, PES_LEN:
            begin
               if (byte_strobe)
               begin
                  if (cnt == 3'd0)
                  begin
                     packet_length[15:8] <= byte_data; // length is big endian
                     cnt                 <= 3'd1;
                  end
                  else
                  begin
                     packet_length[7:0] <= byte_data;
                     if (state == PES_LEN)
                     begin
                        pes_start <= 1'b1;
                        state     <= IN_PACKET;
                     end
                     else if ({packet_length[15:8], byte_data} == '0)
                        state <= HUNT;
                     else
                        state <= SYS_SKIP;
                  end
               end
            end
            SYS_SKIP:
            begin
               if (byte_strobe)
               begin
                  packet_length <= packet_length - 16'd1; // counts down remaining header
                  if (packet_length == 16'd1)
                     state <= HUNT;
               end
            end
            IN_PACKET:
            begin
               // busy rises one cycle after pes_start
               if (!pes_busy && !pes_start)
                  state <= HUNT;
            end
            default:
               state <= HUNT;
         endcase
      end
   end

endmodule

// File: hdl/serial_byte_framer.sv
// Serial byte framer, packs MSB-first bits into bytes and flags bytes after 00 00 01
`timescale 1ns/1ps

module serial_byte_framer (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                serial_in,
   output mpeg_sys_pkg::byte_t byte_data,
   output logic                byte_strobe,
   output logic                after_prefix
);
   import mpeg_sys_pkg::*;

   logic       bit_q;    // input register
   logic       bit_vld;  // bit_q holds a real bit
   logic [2:0] bit_cnt;
   byte_t      shift_q;
   byte_t      prev1;    // last completed byte
   byte_t      prev2;    // the one before it
   logic       zero3;    // byte before prev2 was 00

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         bit_q        <= 1'b0;
         bit_vld      <= 1'b0;
         bit_cnt      <= '0;
         shift_q      <= '0;
         prev1        <= 8'hFF;
         prev2        <= 8'hFF;
         zero3        <= 1'b0;
         byte_strobe  <= 1'b0;
         after_prefix <= 1'b0;
      end
      else
      begin
         bit_q       <= serial_in;
         bit_vld     <= 1'b1;
         byte_strobe <= 1'b0;
         if (bit_vld)
         begin
            shift_q <= {shift_q[6:0], bit_q}; // msb arrives first
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7)
            begin
               byte_strobe  <= 1'b1;
               after_prefix <= zero3 && (prev2 == 8'h00) && (prev1 == 8'h01);
               zero3        <= (prev2 == 8'h00);
               prev2        <= prev1;
               prev1        <= {shift_q[6:0], bit_q};
            end
         end
      end
   end

   assign byte_data = shift_q; // complete while byte_strobe is high

endmodule

// File: hdl/field_load_if.sv
// Field load channel carrying parsed header bytes from a parser to field capture
`timescale 1ns/1ps

interface field_load_if;
   import mpeg_sys_pkg::*;

   byte_t  data;  // header or payload byte
   logic   load;  // one-cycle strobe
   field_e field; // what the byte belongs to
   logic   last;  // final byte of the field

   modport src (
      output data,
      output load,
      output field,
      output last
   );

   modport dst (
      input data,
      input load,
      input field,
      input last
   );
endinterface

// File: hdl/mpeg_sys_pkg.sv
// MPEG-1 system demux package with stream types, start codes and parser enums
package mpeg_sys_pkg;

   typedef logic [7:0]  byte_t;
   typedef logic [32:0] scr_t;      // 90 kHz system clock reference
   typedef logic [32:0] pts_t;      // 90 kHz presentation time stamp
   typedef logic [21:0] mux_rate_t; // units of 50 bytes/s
   typedef logic [15:0] pkt_len_t;

   // start code values, the byte after the 00 00 01 prefix
   localparam byte_t PACK_START_CODE    = 8'hBA;
   localparam byte_t SYSTEM_HEADER_CODE = 8'hBB;
   localparam byte_t END_CODE           = 8'hB9;
   localparam byte_t PRIVATE_2_ID       = 8'hBF;
   localparam byte_t MIN_STREAM_ID      = 8'hBC; // lowest packet stream id

   localparam byte_t STUFFING_BYTE = 8'hFF;
   localparam byte_t NO_TS_BYTE    = 8'h0F;      // packet carries no time stamp
   localparam logic [2:0] TS_MARK  = 3'b001;     // 0010 pts only, 0011 pts + dts

   typedef enum logic [2:0] {
      FIELD_SCR,
      FIELD_MUX_RATE,
      FIELD_STREAM_ID,
      FIELD_PTS,
      FIELD_PAYLOAD
   } field_e;

   typedef enum logic [2:0] {
      HUNT,
      PACK_HDR,
      SYS_LEN,
      SYS_SKIP,
      PES_LEN,
      IN_PACKET
   } pack_state_e;

   typedef enum logic [2:0] {
      IDLE,
      STUFF,
      STD_2ND,
      PTS,
      PTS_DTS,
      DTS_SKIP,
      PAYLOAD
   } pes_state_e;

endpackage
